// ==== run.sh ====
#!/bin/sh
# Builds the register path testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module regPathTb -Mdir obj_dir -o regPathSim -f src.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/regPathSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Pass line not found in $LOG"
	exit 1
fi

// ==== source/opxDecoder.sv ====
`timescale 1ns/1ps

module opxDecoder import regSeqPkg::*; (
	input  logic      CLK,
	input  logic      RESET,
	input  logic      instrAccept,
	input  word_t     instrWord,
	output regSeq_t   regSeq,
	output regIndex_t regAIndex,
	output regIndex_t regBIndex,
	output logic      byteOp
);

	// Held copy of the last accepted word.
	word_t instrReg;
	opcode_t opcode;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instruction capture.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Loads on the accepting edge.
	// Holds through DECODE, EXECUTE, COMMIT and the strobe cycle.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			// Opcode zero decodes to no register cycle.
			instrReg <= '0;
		end else if (instrAccept) begin
			instrReg <= instrWord;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Field split.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Top nibble selects the cycle kind.
	assign opcode = instrReg[OPCODE_LSB +: $bits(opcode_t)];

	// Register numbers for both ports.
	assign regAIndex = instrReg[REGA_LSB +: $bits(regIndex_t)];
	assign regBIndex = instrReg[REGB_LSB +: $bits(regIndex_t)];

	// Byte flag picks byte loads and unit pointer steps.
	assign byteOp = instrReg[BYTE_BIT];

	// Table lookup.
	// Unused opcodes fall to SEQ_NONE.
	assign regSeq = decodeOpcode(opcode);

endmodule

// ==== source/phaseSequencer.sv ====
`timescale 1ns/1ps

module phaseSequencer import regSeqPkg::*; (
	input  logic   CLK,
	input  logic   RESET,
	input  logic   STOPPED,
	input  logic   instrValid,
	output logic   instrReady,
	output logic   instrAccept,
	output phase_t phase
);

	phase_t phaseNext;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instruction handshake.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Ready only while waiting in FETCH and not held.
	assign instrReady = (phase == FETCH) && !STOPPED;
	// A word moves on the edge where both sides agree.
	assign instrAccept = instrReady && instrValid;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Phase ring.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		phaseNext = phase;
		if (!STOPPED) begin
			case (phase)
				// Wait here until the source hands over a word.
				FETCH: begin
					if (instrValid) begin
						phaseNext = DECODE;
					end
				end
				DECODE:  phaseNext = EXECUTE;
				EXECUTE: phaseNext = COMMIT;
				// Back to FETCH for the next word.
				COMMIT:  phaseNext = FETCH;
				default: phaseNext = FETCH;
			endcase
		end
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			phase <= FETCH;
		end else begin
			phase <= phaseNext;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// DECODE, EXECUTE and COMMIT each advance after one cycle when not held.
	busyPhaseSteps: assert property (@(posedge CLK) disable iff (RESET)
		(phase != FETCH) && !STOPPED |=> phase != $past(phase));

endmodule

// ==== source/regPathTop.sv ====
`timescale 1ns/1ps

module regPathTop import regSeqPkg::*; #(
	parameter int wordStep = 2
) (
	input  logic  CLK,
	input  logic  RESET,
	input  logic  STOPPED,
	input  logic  instrValid,
	output logic  instrReady,
	input  word_t instrWord,
	input  word_t writeData,
	output word_t regAData,
	output word_t regBData,
	output logic  regAEnable,
	output logic  regAWrite,
	output logic  regBEnable,
	output logic  regBWrite
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Internal nets.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	phase_t    phase;
	logic      instrAccept;
	regSeq_t   regSeq;
	regIndex_t regAIndex;
	regIndex_t regBIndex;
	logic      byteOp;

	// Phase ring and instruction handshake.
	phaseSequencer phaseSeq (
		.CLK         (CLK),
		.RESET       (RESET),
		.STOPPED     (STOPPED),
		.instrValid  (instrValid),
		.instrReady  (instrReady),
		.instrAccept (instrAccept),
		.phase       (phase)
	);

	// Word capture and field decode.
	opxDecoder opxDec (
		.CLK         (CLK),
		.RESET       (RESET),
		.instrAccept (instrAccept),
		.instrWord   (instrWord),
		.regSeq      (regSeq),
		.regAIndex   (regAIndex),
		.regBIndex   (regBIndex),
		.byteOp      (byteOp)
	);

	// Port enables and write strobes.
	registerSequencer regSeqCtl (
		.CLK        (CLK),
		.RESET      (RESET),
		.phase      (phase),
		.regSeq     (regSeq),
		.regAEnable (regAEnable),
		.regAWrite  (regAWrite),
		.regBEnable (regBEnable),
		.regBWrite  (regBWrite)
	);

	// Eight-entry register file.
	registerFile #(
		.wordStep (wordStep)
	) regFile (
		.CLK        (CLK),
		.RESET      (RESET),
		.regAIndex  (regAIndex),
		.regBIndex  (regBIndex),
		.byteOp     (byteOp),
		.regAEnable (regAEnable),
		.regAWrite  (regAWrite),
		.regBEnable (regBEnable),
		.regBWrite  (regBWrite),
		.writeData  (writeData),
		.regAData   (regAData),
		.regBData   (regBData)
	);

endmodule

// ==== source/regSeqPkg.sv ====
package regSeqPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Vector types.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Register value or instruction word.
	typedef logic [15:0] word_t;
	// Register number for the eight-entry file.
	typedef logic [2:0] regIndex_t;
	// Opcode field of the instruction.
	typedef logic [3:0] opcode_t;

	// Machine phases in ring order.
	typedef enum logic [1:0] {
		FETCH   = 2'd0,
		DECODE  = 2'd1,
		EXECUTE = 2'd2,
		COMMIT  = 2'd3
	} phase_t;

	// Register cycle kinds.
	// The value order follows the opcode numbering.
	typedef enum logic [3:0] {
		SEQ_NONE    = 4'd0,
		SEQ_RDA_RDB = 4'd1,
		SEQ_LDA_RDB = 4'd2,
		SEQ_LDA_UPB = 4'd3,
		SEQ_RDA_UPB = 4'd4,
		SEQ_LDA_IMM = 4'd5,
		SEQ_RDA_IMM = 4'd6,
		SEQ_UPA_RDB = 4'd7,
		SEQ_UPA_IMM = 4'd8,
		SEQ_RDB     = 4'd9
	} regSeq_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instruction layout.
	//   [15:12] opcode.
	//   [11:9]  A register index.
	//   [8:6]   B register index.
	//   [5]     byte flag.
	//   [4:0]   ignored.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int OPCODE_LSB = 12;
	localparam int REGA_LSB   = 9;
	localparam int REGB_LSB   = 6;
	localparam int BYTE_BIT   = 5;

	// Opcode to cycle code table.
	// Opcodes past the last cycle kind run no register cycle.
	function automatic regSeq_t decodeOpcode(input opcode_t opcode);
		regSeq_t seq;
		case (opcode)
			4'd1: seq = SEQ_RDA_RDB;
			4'd2: seq = SEQ_LDA_RDB;
			4'd3: seq = SEQ_LDA_UPB;
			4'd4: seq = SEQ_RDA_UPB;
			4'd5: seq = SEQ_LDA_IMM;
			4'd6: seq = SEQ_RDA_IMM;
			4'd7: seq = SEQ_UPA_RDB;
			4'd8: seq = SEQ_UPA_IMM;
			4'd9: seq = SEQ_RDB;
			default: seq = SEQ_NONE;
		endcase
		return seq;
	endfunction

endpackage

// ==== source/registerFile.sv ====
`timescale 1ns/1ps

module registerFile import regSeqPkg::*; #(
	parameter int wordStep = 2
) (
	input  logic      CLK,
	input  logic      RESET,
	input  regIndex_t regAIndex,
	input  regIndex_t regBIndex,
	input  logic      byteOp,
	input  logic      regAEnable,
	input  logic      regAWrite,
	input  logic      regBEnable,
	input  logic      regBWrite,
	input  word_t     writeData,
	output word_t     regAData,
	output word_t     regBData
);

	localparam int REG_COUNT = 8;

	// Pointer steps for word and byte operations.
	localparam word_t WORD_INC = word_t'(wordStep);
	localparam word_t BYTE_INC = word_t'(1);

	word_t regs [REG_COUNT];

	word_t aLoad;
	word_t bStep;
	logic  sameIndex;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read ports.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// A port that is not enabled reads as zero.
	assign regAData = regAEnable ? regs[regAIndex] : '0;
	assign regBData = regBEnable ? regs[regBIndex] : '0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write values.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Byte load keeps the low byte and zeroes the high byte.
	assign aLoad = byteOp ? {8'h00, writeData[7:0]} : writeData;

	// Pointer advance.
	assign bStep = byteOp ? BYTE_INC : WORD_INC;

	// Both ports aim at one register.
	assign sameIndex = regAIndex == regBIndex;

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			// B update is dropped when A writes the same entry.
			if (regBWrite && !(regAWrite && sameIndex)) begin
				regs[regBIndex] <= regs[regBIndex] + bStep;
			end
			if (regAWrite) begin
				regs[regAIndex] <= aLoad;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Same-entry double write.
	// The B update is lost, so flag it.
	sameIndexWrite: assert property (@(posedge CLK) disable iff (RESET)
		!(regAWrite && regBWrite && sameIndex))
		else $warning("A and B write register %0d together, A kept", regAIndex);

endmodule

// ==== source/registerSequencer.sv ====
`timescale 1ns/1ps

module registerSequencer import regSeqPkg::*; (
	input  logic    CLK,
	input  logic    RESET,
	input  phase_t  phase,
	input  regSeq_t regSeq,
	output logic    regAEnable,
	output logic    regAWrite,
	output logic    regBEnable,
	output logic    regBWrite
);

	// Per-port flags straight from the cycle code.
	logic aEnFlag;
	logic aWrFlag;
	logic bEnFlag;
	logic bWrFlag;

	// Flags captured during DECODE.
	logic aEnHeld;
	logic aWrHeld;
	logic bEnHeld;
	logic bWrHeld;

	// Phase of the previous cycle.
	phase_t lastPhase;

	logic portWindow;
	logic commitDone;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Cycle code to port flags.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		// Idle unless the code says otherwise.
		aEnFlag = 1'b0;
		aWrFlag = 1'b0;
		bEnFlag = 1'b0;
		bWrFlag = 1'b0;
		case (regSeq)
			SEQ_RDA_RDB: begin
				aEnFlag = 1'b1;
				bEnFlag = 1'b1;
			end
			SEQ_LDA_RDB, SEQ_UPA_RDB: begin
				aEnFlag = 1'b1;
				aWrFlag = 1'b1;
				bEnFlag = 1'b1;
			end
			SEQ_LDA_UPB: begin
				aEnFlag = 1'b1;
				aWrFlag = 1'b1;
				bEnFlag = 1'b1;
				bWrFlag = 1'b1;
			end
			SEQ_RDA_UPB: begin
				aEnFlag = 1'b1;
				bEnFlag = 1'b1;
				bWrFlag = 1'b1;
			end
			// Immediate forms leave port B idle.
			SEQ_LDA_IMM, SEQ_UPA_IMM: begin
				aEnFlag = 1'b1;
				aWrFlag = 1'b1;
			end
			SEQ_RDA_IMM: aEnFlag = 1'b1;
			SEQ_RDB:     bEnFlag = 1'b1;
			default: ;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Registered stages.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			aEnHeld   <= 1'b0;
			aWrHeld   <= 1'b0;
			bEnHeld   <= 1'b0;
			bWrHeld   <= 1'b0;
			lastPhase <= FETCH;
		end else begin
			// Decoder outputs are settled by DECODE.
			if (phase == DECODE) begin
				aEnHeld <= aEnFlag;
				aWrHeld <= aWrFlag;
				bEnHeld <= bEnFlag;
				bWrHeld <= bWrFlag;
			end
			lastPhase <= phase;
		end
	end

	// Reads run through EXECUTE and COMMIT.
	assign portWindow = (phase == EXECUTE) || (phase == COMMIT);
	// First FETCH cycle after COMMIT carries the strobe.
	assign commitDone = (phase == FETCH) && (lastPhase == COMMIT);

	assign regAEnable = aEnHeld && portWindow;
	assign regBEnable = bEnHeld && portWindow;
	assign regAWrite  = aWrHeld && commitDone;
	assign regBWrite  = bWrHeld && commitDone;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// A strobe comes right after a COMMIT cycle.
	strobeAfterCommit: assert property (@(posedge CLK) disable iff (RESET)
		(regAWrite || regBWrite) |-> $past(phase) == COMMIT);

	// Strobes are single-cycle pulses.
	strobeAOnce: assert property (@(posedge CLK) disable iff (RESET)
		regAWrite |=> !regAWrite);
	strobeBOnce: assert property (@(posedge CLK) disable iff (RESET)
		regBWrite |=> !regBWrite);

endmodule

// ==== src.f ====
source/regSeqPkg.sv
source/phaseSequencer.sv
source/opxDecoder.sv
source/registerSequencer.sv
source/registerFile.sv
source/regPathTop.sv
test/regPathTb.sv

// ==== test/regPathTb.sv ====
`timescale 1ns/1ps

module regPathTb import regSeqPkg::*; ();

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Settings and stimulus table.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int NUM_ENTRIES  = 20;
	localparam int RESET_CYCLES = 8;
	// Largest idle gap drawn from the LFSR.
	localparam int MAX_GAP      = 3;

	// One instruction with its write data, stall length and valid delay.
	typedef struct packed {
		word_t      instr;
		word_t      data;
		logic [3:0] stall;
		logic [3:0] delay;
	} stimEntry_t;

	logic  CLK;
	logic  RESET;
	logic  STOPPED;
	logic  instrValid;
	logic  instrReady;
	word_t instrWord;
	word_t writeData;
	word_t regAData;
	word_t regBData;
	logic  regAEnable;
	logic  regAWrite;
	logic  regBEnable;
	logic  regBWrite;

	stimEntry_t  stimTable [NUM_ENTRIES];
	// Expected register contents.
	word_t       model [8];
	logic [31:0] lfsrState;
	int          cycleCount = 0;
	int          timeoutLimit = 1000000;

	regPathTop #(
		.wordStep (2)
	) UUT (
		.CLK        (CLK),
		.RESET      (RESET),
		.STOPPED    (STOPPED),
		.instrValid (instrValid),
		.instrReady (instrReady),
		.instrWord  (instrWord),
		.writeData  (writeData),
		.regAData   (regAData),
		.regBData   (regBData),
		.regAEnable (regAEnable),
		.regAWrite  (regAWrite),
		.regBEnable (regBEnable),
		.regBWrite  (regBWrite)
	);

	// 8 ns clock.
	initial CLK = 1'b0;
	always #4 CLK = ~CLK;

	// Run limit.
	always @(posedge CLK) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= timeoutLimit) begin
			$display("Run did not finish within %0d cycles", timeoutLimit);
			$display("TEST FAILED");
			$fatal(1, "Timeout");
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Galois LFSR, one step per bit.
	function automatic logic stepLfsr();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit) begin
			lfsrState = lfsrState ^ 32'h8020_0003;
		end
		return outBit;
	endfunction

	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] bits;
		int i;
		bits = '0;
		for (i = 0; i < count; i++) begin
			bits = {bits[30:0], stepLfsr()};
		end
		return bits;
	endfunction

	// Builds a word from its fields; low five bits left clear.
	function automatic word_t encode(input opcode_t op, input regIndex_t a,
			input regIndex_t b, input logic byteFlag);
		return {op, a, b, byteFlag, 5'b00000};
	endfunction

	// Port behavior per opcode as {aEnable, aWrite, bEnable, bWrite}.
	function automatic logic [3:0] portFlags(input opcode_t op);
		case (op)
			4'd1: return 4'b1010;
			4'd2: return 4'b1110;
			4'd3: return 4'b1111;
			4'd4: return 4'b1011;
			4'd5: return 4'b1100;
			4'd6: return 4'b1000;
			4'd7: return 4'b1110;
			4'd8: return 4'b1100;
			4'd9: return 4'b0010;
			// Unused opcodes touch no port.
			default: return 4'b0000;
		endcase
	endfunction

	task automatic checkWord(input string name, input word_t got, input word_t expected);
		if (got !== expected) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, expected);
			$display("TEST FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, expected);
			$display("TEST FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Enables, strobes and read data for one cycle.
	task automatic checkOutputs(input logic [3:0] flags, input logic portsOn,
			input logic strobesOn, input regIndex_t aIdx, input regIndex_t bIdx);
		logic aEn;
		logic bEn;
		aEn = flags[3] && portsOn;
		bEn = flags[1] && portsOn;
		checkFlag("regAEnable", regAEnable, aEn);
		checkFlag("regBEnable", regBEnable, bEn);
		checkFlag("regAWrite", regAWrite, flags[2] && strobesOn);
		checkFlag("regBWrite", regBWrite, flags[0] && strobesOn);
		// A disabled port reads zero.
		checkWord("regAData", regAData, aEn ? model[aIdx] : '0);
		checkWord("regBData", regBData, bEn ? model[bIdx] : '0);
	endtask

	// Holds the phase ring; outputs must not move meanwhile.
	task automatic holdStall(input int cycles, input logic [3:0] flags, input logic portsOn,
			input regIndex_t aIdx, input regIndex_t bIdx);
		if (cycles > 0) begin
			STOPPED = 1'b1;
			repeat (cycles) begin
				@(negedge CLK);
				checkFlag("instrReady", instrReady, 1'b0);
				checkOutputs(flags, portsOn, 1'b0, aIdx, bIdx);
			end
			STOPPED = 1'b0;
		end
	endtask

	// Byte loads zero the high byte and B steps by 2 or 1.
	// A wins on a tie.
	task automatic updateModel(input logic [3:0] flags, input regIndex_t aIdx,
			input regIndex_t bIdx, input logic byteFlag, input word_t data);
		word_t loadValue;
		word_t step;
		loadValue = byteFlag ? {8'h00, data[7:0]} : data;
		step = byteFlag ? 16'd1 : 16'd2;
		if (flags[2] && flags[0] && (aIdx == bIdx)) begin
			model[aIdx] = loadValue;
		end else begin
			if (flags[0]) begin
				model[bIdx] = model[bIdx] + step;
			end
			if (flags[2]) begin
				model[aIdx] = loadValue;
			end
		end
	endtask

	// One instruction from handshake through the strobe cycle.
	task automatic runEntry(input stimEntry_t entry);
		opcode_t    op;
		regIndex_t  aIdx;
		regIndex_t  bIdx;
		logic       byteFlag;
		logic [3:0] flags;
		logic       stallInDecode;
		int         idle;
		op = entry.instr[15:12];
		aIdx = entry.instr[11:9];
		bIdx = entry.instr[8:6];
		byteFlag = entry.instr[5];
		flags = portFlags(op);
		idle = int'(entry.delay) + int'(randomBits(2));
		stallInDecode = stepLfsr();
		// Idle FETCH cycles.
		// Write data is noise here and no port may move.
		repeat (idle) begin
			@(negedge CLK);
			writeData = word_t'(randomBits(16));
			checkFlag("instrReady", instrReady, 1'b1);
			checkOutputs(4'b0000, 1'b0, 1'b0, aIdx, bIdx);
		end
		// Ignored low bits get random fill.
		instrWord = entry.instr | word_t'(randomBits(5));
		instrValid = 1'b1;
		while (!instrReady) begin
			@(negedge CLK);
		end
		// DECODE.
		@(negedge CLK);
		instrValid = 1'b0;
		instrWord = word_t'(randomBits(16));
		writeData = entry.data;
		checkFlag("instrReady", instrReady, 1'b0);
		checkOutputs(flags, 1'b0, 1'b0, aIdx, bIdx);
		if (stallInDecode) begin
			holdStall(int'(entry.stall), flags, 1'b0, aIdx, bIdx);
		end
		// EXECUTE.
		@(negedge CLK);
		checkOutputs(flags, 1'b1, 1'b0, aIdx, bIdx);
		if (!stallInDecode) begin
			holdStall(int'(entry.stall), flags, 1'b1, aIdx, bIdx);
		end
		// COMMIT.
		@(negedge CLK);
		checkOutputs(flags, 1'b1, 1'b0, aIdx, bIdx);
		// Strobe cycle, back in FETCH.
		@(negedge CLK);
		checkOutputs(flags, 1'b0, 1'b1, aIdx, bIdx);
		checkFlag("instrReady", instrReady, 1'b1);
		updateModel(flags, aIdx, bIdx, byteFlag, entry.data);
	endtask

	task automatic loadTable();
		stimTable[0]  = '{encode(4'd5, 3'd1, 3'd0, 1'b0), 16'hA5C3, 4'd0, 4'd0};
		stimTable[1]  = '{encode(4'd5, 3'd2, 3'd0, 1'b1), 16'h7E42, 4'd1, 4'd2};
		stimTable[2]  = '{encode(4'd2, 3'd3, 3'd1, 1'b0), 16'h1234, 4'd2, 4'd0};
		stimTable[3]  = '{encode(4'd1, 3'd1, 3'd2, 1'b0), 16'hFFFF, 4'd0, 4'd1};
		stimTable[4]  = '{encode(4'd3, 3'd4, 3'd5, 1'b0), 16'hBEEF, 4'd3, 4'd0};
		stimTable[5]  = '{encode(4'd4, 3'd6, 3'd5, 1'b1), 16'h0000, 4'd1, 4'd3};
		stimTable[6]  = '{encode(4'd4, 3'd0, 3'd3, 1'b0), 16'h0000, 4'd0, 4'd0};
		// Same index on both ports.
		stimTable[7]  = '{encode(4'd3, 3'd7, 3'd7, 1'b0), 16'h0F0F, 4'd2, 4'd1};
		stimTable[8]  = '{encode(4'd6, 3'd7, 3'd0, 1'b0), 16'h5555, 4'd1, 4'd0};
		stimTable[9]  = '{encode(4'd7, 3'd0, 3'd5, 1'b1), 16'hFFC8, 4'd0, 4'd2};
		stimTable[10] = '{encode(4'd8, 3'd5, 3'd0, 1'b0), 16'h8001, 4'd3, 4'd0};
		stimTable[11] = '{encode(4'd9, 3'd0, 3'd5, 1'b0), 16'h2222, 4'd0, 4'd0};
		// No-op code and unused opcodes.
		stimTable[12] = '{encode(4'd0, 3'd1, 3'd2, 1'b0), 16'h3333, 4'd1, 4'd1};
		stimTable[13] = '{encode(4'd10, 3'd1, 3'd2, 1'b0), 16'hDEAD, 4'd0, 4'd0};
		stimTable[14] = '{encode(4'd13, 3'd3, 3'd4, 1'b1), 16'hBEAD, 4'd2, 4'd3};
		stimTable[15] = '{encode(4'd15, 3'd6, 3'd7, 1'b0), 16'hFACE, 4'd1, 4'd0};
		// Read back earlier results.
		stimTable[16] = '{encode(4'd1, 3'd3, 3'd4, 1'b0), 16'h0000, 4'd0, 4'd2};
		stimTable[17] = '{encode(4'd3, 3'd2, 3'd6, 1'b1), 16'h33CC, 4'd1, 4'd0};
		stimTable[18] = '{encode(4'd1, 3'd2, 3'd6, 1'b0), 16'h0000, 4'd2, 4'd1};
		stimTable[19] = '{encode(4'd1, 3'd0, 3'd7, 1'b1), 16'h0000, 4'd0, 4'd0};
	endtask

	// Worst case per entry plus slack for reset and the stop check.
	function automatic int computeTimeout();
		int maxStall;
		int maxDelay;
		maxStall = 0;
		maxDelay = 0;
		foreach (stimTable[i]) begin
			if (int'(stimTable[i].stall) > maxStall) begin
				maxStall = int'(stimTable[i].stall);
			end
			if (int'(stimTable[i].delay) > maxDelay) begin
				maxDelay = int'(stimTable[i].delay);
			end
		end
		maxDelay = maxDelay + MAX_GAP;
		return NUM_ENTRIES * (4 + maxStall + maxDelay) + 50;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		lfsrState = 32'he558_f17a;
		loadTable();
		timeoutLimit = computeTimeout();
		foreach (model[i]) begin
			model[i] = '0;
		end
		RESET = 1'b1;
		STOPPED = 1'b0;
		instrValid = 1'b0;
		instrWord = '0;
		writeData = '0;
		repeat (RESET_CYCLES) @(negedge CLK);
		RESET = 1'b0;
		// Idle FETCH after reset.
		@(negedge CLK);
		checkFlag("instrReady", instrReady, 1'b1);
		checkOutputs(4'b0000, 1'b0, 1'b0, 3'd0, 3'd0);
		// Stop drops ready.
		STOPPED = 1'b1;
		repeat (2) begin
			@(negedge CLK);
			checkFlag("instrReady", instrReady, 1'b0);
		end
		STOPPED = 1'b0;
		@(negedge CLK);
		checkFlag("instrReady", instrReady, 1'b1);
		foreach (stimTable[i]) begin
			runEntry(stimTable[i]);
		end
		$display("TEST OK");
		$finish;
	end

endmodule
